// ==== design/binUpdateIf.sv ====
// interface for one histogram bin update, builder to peak detector
`timescale 1ns/100ps

interface binUpdateIf;
    import sifhPkg::*;

    // one update per cycle with valid high, no back-pressure
    logic     valid;
    pixelIdxT pixel;
    binAddrT  bin;
    // count after the increment
    binCountT count;

    modport source (
        output valid,
        output pixel,
        output bin,
        output count
    );

    modport sink (
        input valid,
        input pixel,
        input bin,
        input count
    );

endinterface

// ==== design/dataFilter.sv ====
// sample filter: bin address per pass, drops no-photon and out-of-window codes
`timescale 1ns/100ps
`include "sifh_params.svh"

module dataFilter (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    wrEn,
    input  sifhPkg::timestampT                      data,
    input  logic                                    pass,
    input  sifhPkg::pixelIdxT                       pixel,
    input  sifhPkg::timestampT [`SIFH_PIXELS-1:0]   winLower,
    output logic                                    sampleValid,
    output sifhPkg::pixelIdxT                       samplePixel,
    output sifhPkg::binAddrT                        sampleBin
);
    import sifhPkg::*;

    localparam timestampT NO_PHOTON = '1;
    // fine window spans 2^Nb codes
    localparam logic [`SIFH_NP:0] WIN_SPAN = (`SIFH_NP+1)'(`SIFH_BINS);

    timestampT         lower;
    logic [`SIFH_NP:0] offset;
    logic              inWindow;
    logic              keep;
    binAddrT           binNext;

    always_comb begin
        lower = winLower[pixel];
        // extra msb catches data below the lower bound
        offset = {1'b0, data} - {1'b0, lower};
        inWindow = !offset[`SIFH_NP] && (offset < WIN_SPAN);
        // coarse pass uses top bits, fine pass the window offset
        if (pass) begin
            binNext = offset[`SIFH_NB-1:0];
        end else begin
            binNext = data[`SIFH_NP-1 -: `SIFH_NB];
        end
        keep = wrEn && (data != NO_PHOTON) && (!pass || inWindow);
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= keep;
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (keep) begin
            samplePixel <= pixel;
            sampleBin   <= binNext;
        end
    end

endmodule

// ==== design/frameSequencer.sv ====
// sample, pixel and acquisition counters, pass FSM, drains, clear and latch pulses
`timescale 1ns/100ps
`include "sifh_params.svh"

module frameSequencer (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    output logic               pass,
    output sifhPkg::pixelIdxT  pixel,
    output logic               histClear,
    output logic               latchWindow,
    output logic               latchResult,
    output logic               acqReady
);
    import sifhPkg::*;

    localparam int SAMPLE_W = $clog2(`SIFH_DATA_NUM);
    localparam int ACQ_W    = $clog2(`SIFH_ACQ_NUM);
    localparam int DRAIN_W  = $clog2(`SIFH_DRAIN + 1);

    seqStateT            state;
    logic [SAMPLE_W-1:0] sampleCnt;
    pixelIdxT            pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;
    logic [DRAIN_W-1:0]  drainCnt;

    logic sampleTake;
    logic sampleWrap;
    logic pixelWrap;
    logic lastSample;
    logic drainDone;

    // ********************************************************************
    // decode
    // ********************************************************************

    always_comb begin
        // source may write only in the two counting states
        acqReady    = (state == COARSE) || (state == FINE);
        pass        = (state == FINE) || (state == DRAIN_F);
        pixel       = pixelCnt;
        sampleTake  = wrEn && acqReady;
        sampleWrap  = sampleCnt == SAMPLE_W'(`SIFH_DATA_NUM - 1);
        pixelWrap   = pixelCnt == pixelIdxT'(`SIFH_PIXELS - 1);
        lastSample  = sampleWrap && pixelWrap && (acqCnt == ACQ_W'(`SIFH_ACQ_NUM - 1));
        drainDone   = drainCnt == DRAIN_W'(`SIFH_DRAIN - 1);
        // latches fire in the last drain cycle
        latchWindow = (state == DRAIN_C) && drainDone;
        latchResult = (state == DRAIN_F) && drainDone;
    end

    // ********************************************************************
    // counters
    // ********************************************************************

    // all three wrap together on the last sample of a pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (sampleTake) begin
            sampleCnt <= sampleWrap ? '0 : sampleCnt + SAMPLE_W'(1);
            if (sampleWrap) begin
                pixelCnt <= pixelWrap ? '0 : pixelCnt + pixelIdxT'(1);
                if (pixelWrap) begin
                    acqCnt <= lastSample ? '0 : acqCnt + ACQ_W'(1);
                end
            end
        end
    end

    // ********************************************************************
    // pass FSM
    // ********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= COARSE;
            drainCnt  <= '0;
            histClear <= 1'b0;
        end else begin
            // clear follows each latch by one cycle
            histClear <= latchWindow || latchResult;
            case (state)
                COARSE: begin
                    if (sampleTake && lastSample) begin
                        state <= DRAIN_C;
                    end
                end
                DRAIN_C: begin
                    drainCnt <= drainDone ? '0 : drainCnt + DRAIN_W'(1);
                    if (drainDone) begin
                        state <= FINE;
                    end
                end
                FINE: begin
                    if (sampleTake && lastSample) begin
                        state <= DRAIN_F;
                    end
                end
                default: begin
                    // DRAIN_F, frame done afterwards
                    drainCnt <= drainDone ? '0 : drainCnt + DRAIN_W'(1);
                    if (drainDone) begin
                        state <= COARSE;
                    end
                end
            endcase
        end
    end

    // writes during a drain are lost, so the source must watch acqReady
    a_wrDuringDrain: assert property (@(posedge clk) disable iff (!combin_res)
        wrEn |-> acqReady)
        else $error("write strobe while acquisition not ready");

endmodule

// ==== design/histogramBuilder.sv ====
// per-pixel histogram in flops with lazy clear and single-cycle increment
`timescale 1ns/100ps
`include "sifh_params.svh"

module histogramBuilder (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               histClear,
    input  logic               sampleValid,
    input  sifhPkg::pixelIdxT  samplePixel,
    input  sifhPkg::binAddrT   sampleBin,
    binUpdateIf.source         upd
);
    import sifhPkg::*;

    // ********************************************************************
    // storage
    // ********************************************************************

    // bin counts, meaningful only where the valid bit is set
    binCountT countArr [`SIFH_PIXELS][`SIFH_BINS];
    // one valid bit per bin, clearing them empties every histogram
    logic [`SIFH_PIXELS-1:0][`SIFH_BINS-1:0] binValid;

    binCountT curCount;
    binCountT newCount;

    // read side, stale bins read as zero
    always_comb begin
        if (binValid[samplePixel][sampleBin]) begin
            curCount = countArr[samplePixel][sampleBin];
        end else begin
            curCount = '0;
        end
        newCount = curCount + binCountT'(1);
    end

    // ********************************************************************
    // update
    // ********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid  <= '0;
            upd.valid <= 1'b0;
        end else if (histClear) begin
            binValid  <= '0;
            upd.valid <= 1'b0;
        end else begin
            upd.valid <= sampleValid;
            if (sampleValid) begin
                binValid[samplePixel][sampleBin] <= 1'b1;
            end
        end
    end

    // array write lands before the next read, so repeats need no bypass
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            countArr[samplePixel][sampleBin] <= newCount;
        end
    end

    // new count travels to the peak detector
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            upd.pixel <= samplePixel;
            upd.bin   <= sampleBin;
            upd.count <= newCount;
        end
    end

    // frame geometry must keep every bin below its counter limit
    a_noWrap: assert property (@(posedge clk) disable iff (!combin_res)
        sampleValid && !histClear |-> newCount != '0)
        else $error("histogram bin count wrapped");

endmodule

// ==== design/peakDetector.sv ====
// running maximum per pixel, bin of the first bin to reach it
`timescale 1ns/100ps
`include "sifh_params.svh"

module peakDetector (
    input  logic                                  clk,
    input  logic                                  combin_res,
    input  logic                                  histClear,
    binUpdateIf.sink                              upd,
    output sifhPkg::binAddrT [`SIFH_PIXELS-1:0]   peakBins
);
    import sifhPkg::*;

    // highest count seen per pixel in this pass
    binCountT maxCount [`SIFH_PIXELS];

    logic beatsMax;

    // strict compare, ties keep the earlier bin
    always_comb begin
        beatsMax = upd.valid && (upd.count > maxCount[upd.pixel]);
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                maxCount[p] <= '0;
                peakBins[p] <= '0;
            end
        end else if (histClear) begin
            // new pass starts from an empty histogram
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                maxCount[p] <= '0;
                peakBins[p] <= '0;
            end
        end else if (beatsMax) begin
            maxCount[upd.pixel] <= upd.count;
            peakBins[upd.pixel] <= upd.bin;
        end
    end

endmodule

// ==== design/sifhPkg.sv ====
// shared types: timestamp, bin address, bin count, pixel index, sequencer state
`include "sifh_params.svh"

package sifhPkg;

    // one photon time code, all ones means no photon
    typedef logic [`SIFH_NP-1:0] timestampT;

    // histogram bin index
    typedef logic [`SIFH_NB-1:0] binAddrT;

    // occupancy of one bin
    typedef logic [`SIFH_CNT_W-1:0] binCountT;

    // pixel number within the array
    typedef logic [$clog2(`SIFH_PIXELS)-1:0] pixelIdxT;

    // pass sequence of one frame
    typedef enum logic [1:0] {
        COARSE,
        DRAIN_C,
        FINE,
        DRAIN_F
    } seqStateT;

endpackage

// ==== design/sifhTop.sv ====
// top level of the two-pass depth estimator, plain ports
`timescale 1ns/100ps
`include "sifh_params.svh"

module sifhTop (
    input  logic                               clk,
    input  logic                               combin_res,
    input  logic                               wrEn,
    input  logic [`SIFH_NP-1:0]                data,
    output logic                               acqReady,
    output logic                               resultValid,
    output logic [`SIFH_PIXELS*`SIFH_NP-1:0]   result
);
    import sifhPkg::*;

    // ********************************************************************
    // internal nets
    // ********************************************************************

    logic     pass;
    pixelIdxT pixel;
    logic     histClear;
    logic     latchWindow;
    logic     latchResult;
    logic     sampleWr;

    logic     sampleValid;
    pixelIdxT samplePixel;
    binAddrT  sampleBin;

    binAddrT   [`SIFH_PIXELS-1:0] peakBins;
    timestampT [`SIFH_PIXELS-1:0] winLower;

    binUpdateIf updBus ();

    // samples offered during a drain never reach the filter
    assign sampleWr = wrEn && acqReady;

    // ********************************************************************
    // blocks
    // ********************************************************************

    frameSequencer u_frameSequencer (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .pass        (pass),
        .pixel       (pixel),
        .histClear   (histClear),
        .latchWindow (latchWindow),
        .latchResult (latchResult),
        .acqReady    (acqReady)
    );

    dataFilter u_dataFilter (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (sampleWr),
        .data        (data),
        .pass        (pass),
        .pixel       (pixel),
        .winLower    (winLower),
        .sampleValid (sampleValid),
        .samplePixel (samplePixel),
        .sampleBin   (sampleBin)
    );

    histogramBuilder u_histogramBuilder (
        .clk         (clk),
        .combin_res  (combin_res),
        .histClear   (histClear),
        .sampleValid (sampleValid),
        .samplePixel (samplePixel),
        .sampleBin   (sampleBin),
        .upd         (updBus.source)
    );

    peakDetector u_peakDetector (
        .clk        (clk),
        .combin_res (combin_res),
        .histClear  (histClear),
        .upd        (updBus.sink),
        .peakBins   (peakBins)
    );

    // pixel 0 lands in the low bits of result
    windowCalc u_windowCalc (
        .clk         (clk),
        .combin_res  (combin_res),
        .latchWindow (latchWindow),
        .latchResult (latchResult),
        .peakBins    (peakBins),
        .winLower    (winLower),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

// ==== design/sifh_params.svh ====
// widths, frame geometry and drain length of the depth estimator
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp width in bits
`define SIFH_NP 8

// histogram address width, bins per histogram
`define SIFH_NB 4
`define SIFH_BINS (1 << `SIFH_NB)

// pixels served by one estimator
`define SIFH_PIXELS 4

// samples per pixel in one acquisition
`define SIFH_DATA_NUM 4

// acquisitions per pass
`define SIFH_ACQ_NUM 3

// bin counter width, must hold DATA_NUM * ACQ_NUM
`define SIFH_CNT_W 6

// idle cycles between passes so the pipeline empties
`define SIFH_DRAIN 3

`endif

// ==== design/windowCalc.sv ====
// fine window bounds from coarse peaks, final depth per pixel
`timescale 1ns/100ps
`include "sifh_params.svh"

module windowCalc (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    latchWindow,
    input  logic                                    latchResult,
    input  sifhPkg::binAddrT [`SIFH_PIXELS-1:0]     peakBins,
    output sifhPkg::timestampT [`SIFH_PIXELS-1:0]   winLower,
    output sifhPkg::timestampT [`SIFH_PIXELS-1:0]   result,
    output logic                                    resultValid
);
    import sifhPkg::*;

    // half window, SB
    localparam timestampT HALF = timestampT'(`SIFH_BINS / 2);
    // highest code, all ones
    localparam timestampT TOP = '1;
    // highest legal lower bound, top - 1 - 2*SB
    localparam timestampT CLAMP = TOP - timestampT'(`SIFH_BINS) - timestampT'(1);

    // ********************************************************************
    // window rule
    // ********************************************************************

    function automatic timestampT calcLower(binAddrT peak);
        timestampT centre;
        // coarse bin back on the full code scale
        centre = {peak, {(`SIFH_NP - `SIFH_NB){1'b0}}};
        if (centre <= HALF) begin
            return '0;
        end else if (centre > CLAMP) begin
            return CLAMP;
        end else begin
            return centre - HALF;
        end
    endfunction

    logic winOk;

    // every window must fit below the top code
    always_comb begin
        winOk = 1'b1;
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            if ({1'b0, winLower[p]} + (`SIFH_NP+1)'(`SIFH_BINS) > {1'b0, TOP}) begin
                winOk = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLower <= '0;
        end else if (latchWindow) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                winLower[p] <= calcLower(peakBins[p]);
            end
        end
    end

    // ********************************************************************
    // result
    // ********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= latchResult;
        end
    end

    // depth holds until the next frame ends
    always_ff @(posedge clk) begin
        if (latchResult) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                result[p] <= winLower[p] + timestampT'(peakBins[p]);
            end
        end
    end

    a_winRange: assert property (@(posedge clk) disable iff (!combin_res) winOk)
        else $error("fine window exceeds the code range");

endmodule

// ==== runSim.sh ====
#!/bin/sh
# build and run the depth estimator testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tbSifh -Mdir obj_dir -f sifhTop.f \
    && ./obj_dir/VtbSifh > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log \
    && { echo "simulation result: pass"; exit 0; } \
    || { echo "simulation result: fail"; exit 1; }

// ==== sifhTop.f ====
+incdir+design
design/sifhPkg.sv
design/binUpdateIf.sv
design/dataFilter.sv
design/histogramBuilder.sv
design/peakDetector.sv
design/windowCalc.sv
design/frameSequencer.sv
design/sifhTop.sv
testbench/tbSifh.sv

// ==== testbench/sifh_trace.txt ====
# frame count, then per frame 96 pairs of timestamp (hex) and idle gap before it (dec),
# coarse acq 0..2 then fine acq 0..2, then four expected results (hex), pixel 0 first
4
52 2 55 0 58 0 31 0 A0 0 A7 1 AF 0 A2 0 20 0 24 0 2C 0 70 0 C3 0 C5 0 CE 3 D0 0
52 0 55 0 58 0 31 0 A0 0 A7 0 AF 0 A2 0 20 0 24 0 2C 0 70 0 C3 0 C5 0 CE 0 D0 0
52 0 55 0 58 0 31 0 A0 0 A7 0 AF 0 A2 0 20 1 24 0 2C 0 70 0 C3 0 C5 0 CE 0 D0 0
53 0 53 0 54 0 53 0 A1 0 A1 0 9C 0 A1 1 1A 0 1A 0 1A 0 25 0 C6 0 C6 0 C0 0 C6 0
53 0 53 0 54 0 53 0 A1 0 A1 0 9C 0 A1 0 1A 0 1A 0 1A 0 25 0 C6 0 C6 0 C0 0 C6 0
53 0 53 0 54 0 53 0 A1 0 A1 0 9C 0 A1 0 1A 0 1A 0 1A 0 25 0 C6 0 C6 0 C0 0 C6 0
53 A1 1A C6
02 0 05 0 03 0 01 0 F2 0 F5 0 F8 0 F1 0 11 0 12 0 13 0 14 0 E0 0 E1 0 E5 0 40 0
02 0 05 0 03 0 01 0 F2 0 F5 0 F8 0 F1 0 11 0 12 0 13 0 14 0 E0 0 E1 0 E5 0 40 0
02 0 05 0 03 0 01 0 F2 0 F5 0 F8 0 F1 0 11 0 12 0 13 0 14 0 E0 0 E1 0 E5 0 40 0
04 0 04 0 04 0 0E 0 FA 0 FA 0 FA 0 F0 0 09 0 09 0 09 0 17 0 E7 0 E7 0 E7 0 D8 0
04 0 04 0 04 0 0E 0 FA 0 FA 0 FA 0 F0 0 09 0 09 0 09 0 17 0 E7 0 E7 0 E7 0 D8 0
04 0 04 0 04 0 0E 0 FA 0 FA 0 FA 0 F0 0 09 0 09 0 09 0 17 0 E7 0 E7 0 E7 0 D8 0
04 FA 09 E7
52 0 55 0 58 0 FF 0 A0 0 A7 0 AF 0 FF 0 20 0 24 0 2C 0 FF 0 C3 0 C5 0 CE 0 FF 0
52 0 55 0 58 0 FF 0 A0 0 A7 0 AF 0 FF 0 20 0 24 0 2C 0 FF 0 C3 0 C5 0 CE 0 FF 0
52 0 55 0 58 0 FF 0 A0 0 A7 0 AF 0 FF 0 20 0 24 0 2C 0 FF 0 C3 0 C5 0 CE 0 FF 0
53 0 53 0 54 0 47 0 A1 0 A1 0 A8 0 A1 0 1A 0 1A 0 1A 0 FF 0 C6 0 C6 0 10 0 C6 0
53 0 53 0 54 0 47 0 A1 0 A1 0 A8 0 A1 0 1A 0 1A 0 1A 0 FF 0 C6 0 C6 0 10 0 C6 0
53 0 53 0 54 0 47 0 A1 0 A1 0 A8 0 A1 0 1A 0 1A 0 1A 0 FF 0 C6 0 C6 0 10 0 C6 0
53 A1 1A C6
30 0 30 0 70 0 70 0 90 0 90 0 60 0 60 0 80 0 80 0 80 0 80 0 45 0 46 0 B0 0 B1 0
30 0 30 0 70 0 70 0 90 0 90 0 60 0 60 0 80 0 80 0 80 0 80 0 45 0 46 0 B0 0 B1 0
30 0 30 0 70 0 70 0 90 0 90 0 60 0 60 0 80 0 80 0 80 0 80 0 45 0 46 0 B0 0 B1 0
2A 0 2A 0 2E 0 2E 0 95 0 95 0 8A 0 8A 0 7F 0 7F 0 7F 0 7F 0 3C 0 3D 0 3C 0 3D 0
2A 0 2A 0 2E 0 2E 0 95 0 95 0 8A 0 8A 0 7F 0 7F 0 7F 0 7F 0 3C 0 3D 0 3C 0 3D 0
2A 0 2A 0 2E 0 2E 0 95 0 95 0 8A 0 8A 0 7F 0 7F 0 7F 0 7F 0 3C 0 3D 0 3C 0 3D 0
2A 95 7F 3C

// ==== testbench/tbSifh.sv ====
// trace-driven testbench for the two-pass depth estimator: stimulus, checks, summary
`timescale 1ns/100ps
`include "sifh_params.svh"

module tbSifh;

    // timestamps per frame, coarse and fine pass
    localparam int SAMPLES = 2 * `SIFH_ACQ_NUM * `SIFH_PIXELS * `SIFH_DATA_NUM;
    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic                             clk;
    logic                             combin_res;
    logic                             wrEn;
    logic [`SIFH_NP-1:0]              data;
    logic                             acqReady;
    logic                             resultValid;
    logic [`SIFH_PIXELS*`SIFH_NP-1:0] result;

    int errCount;
    int checkCount;
    int edgeCount;
    int lowRun;
    int drainRuns;
    bit aborted;

    sifhTop u_sifhTop (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .acqReady    (acqReady),
        .resultValid (resultValid),
        .result      (result)
    );

    // ************************************************************************
    // clock and cycle count
    // ************************************************************************

    always #5 clk = ~clk;

    // rising edges so far, read on the falling edge
    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // every low stretch of acqReady is exactly one drain
    always @(negedge clk) begin
        if (combin_res) begin
            if (!acqReady) begin
                lowRun++;
            end else if (lowRun != 0) begin
                checkVal("acqReady low cycles", 32'(lowRun), 32'(`SIFH_DRAIN));
                lowRun = 0;
                drainRuns++;
            end
        end
    end

    // ************************************************************************
    // stimulus tasks
    // ************************************************************************

    // idle gap, then wait for acqReady, then one write on the falling edge
    task automatic sendSample(input logic [`SIFH_NP-1:0] ts, input int gap,
                              output int driveEdge);
        int waitCnt;
        waitCnt = 0;
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            wrEn = 1'b0;
        end
        @(negedge clk);
        while (!acqReady && waitCnt < WAIT_LIMIT) begin
            wrEn = 1'b0;
            @(negedge clk);
            waitCnt++;
        end
        if (!acqReady) begin
            $display("timeout: acqReady stayed low while a sample was pending");
            wrEn    = 1'b0;
            aborted = 1'b1;
        end else begin
            wrEn = 1'b1;
            data = ts;
        end
        driveEdge = edgeCount;
    endtask

    // resultValid expected drain + 1 cycles after the last fine write
    task automatic awaitResult(input int lastEdge);
        int waitCnt;
        waitCnt = 0;
        do begin
            @(negedge clk);
            wrEn = 1'b0;
            waitCnt++;
        end while (!resultValid && waitCnt < WAIT_LIMIT);
        if (!resultValid) begin
            $display("timeout: resultValid never rose after the fine pass");
            aborted = 1'b1;
        end else begin
            checkVal("resultValid latency", 32'(edgeCount - lastEdge),
                     32'(`SIFH_DRAIN + 1));
        end
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************

    initial begin
        int                  fd;
        int                  rc;
        int                  numFrames;
        int                  gap;
        int                  lastEdge;
        logic [`SIFH_NP-1:0] ts;
        logic [`SIFH_NP-1:0] expVal;
        logic [8*160-1:0]    headerLine;

        clk        = 1'b0;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        errCount   = 0;
        checkCount = 0;
        edgeCount  = 0;
        lowRun     = 0;
        drainRuns  = 0;
        aborted    = 1'b0;
        numFrames  = 0;
        lastEdge   = 0;

        fd = $fopen("testbench/sifh_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            aborted = 1'b1;
        end

        repeat (16) @(negedge clk);
        combin_res = 1'b1;

        // two comment lines, then the frame count
        if (!aborted) begin
            rc = $fgets(headerLine, fd);
            rc = $fgets(headerLine, fd);
            rc = $fscanf(fd, "%d", numFrames);
            if (rc != 1) begin
                $display("trace file has no frame count");
                aborted = 1'b1;
            end
        end

        for (int f = 0; f < numFrames && !aborted; f++) begin
            for (int s = 0; s < SAMPLES && !aborted; s++) begin
                rc = $fscanf(fd, "%h %d", ts, gap);
                if (rc != 2) begin
                    $display("trace file ended inside frame %0d", f);
                    aborted = 1'b1;
                end else begin
                    sendSample(ts, gap, lastEdge);
                end
            end
            if (!aborted) begin
                awaitResult(lastEdge);
            end
            // pixel 0 in the low byte
            for (int p = 0; p < `SIFH_PIXELS && !aborted; p++) begin
                rc = $fscanf(fd, "%h", expVal);
                if (rc != 1) begin
                    $display("trace file misses an expected result in frame %0d", f);
                    aborted = 1'b1;
                end else begin
                    checkVal($sformatf("result[%0d] frame %0d", p, f),
                             32'(result[p*`SIFH_NP +: `SIFH_NP]), 32'(expVal));
                end
            end
            // single-cycle pulse
            if (!aborted) begin
                @(negedge clk);
                checkVal("resultValid", 32'(resultValid), 32'(0));
            end
        end

        // coarse and fine drain in every frame
        if (!aborted) begin
            checkVal("acqReady drain count", 32'(drainRuns), 32'(2 * numFrames));
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("summary: %0d checks, %0d errors%s", checkCount, errCount,
                 aborted ? ", run aborted" : "");
        if (errCount == 0 && !aborted && checkCount > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
